// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_qpimem_cached
BUILD_DIR ?= build
LOG ?= sim.log
FILELIST ?= qpimem_cached_top.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== qpimem_cached_top.f ====
src/qpimem_pkg.sv
src/qpimem_cache_tags.sv
src/qpimem_cache.sv
src/qpimem_iface.sv
src/qpimem_cached_top.sv
sim/psram_model.sv
sim/qpimem_checker.sv
sim/tb_qpimem_cached.sv

// ==== sim/psram_model.sv ====
`timescale 1ns/1ps

module psram_model (
	input  qpimem_pkg::qpi_pins_t  pins,
	output logic [3:0]             sio_in
);

	// Sparse word store, untouched words follow the fill pattern
	logic [31:0] mem [logic [qpimem_pkg::ADDR_WIDTH-1:0]];

	logic sclk;
	logic cs_n;
	int unsigned sclk_cnt = 0;
	logic [7:0] cmd = 8'h00;
	qpimem_pkg::byte_addr_t base = '0;
	logic [3:0] drive = 4'h0;

	assign sclk = pins.sclk;
	assign cs_n = pins.cs_n;
	assign sio_in = drive;

	function automatic logic [31:0] word_at(input logic [qpimem_pkg::ADDR_WIDTH-1:0] wa);
		if (mem.exists(wa))
			return mem[wa];
		return 32'(wa) * 32'h9E37_79B9;
	endfunction

	// Nibble k of a line, byte 0 first and high nibble first
	function automatic logic [3:0] nibble_at(input qpimem_pkg::byte_addr_t ba,
		input int unsigned k);
		qpimem_pkg::byte_addr_t b;
		logic [31:0] w;
		logic [7:0] by;
		b = ba + 24'(k / 2);
		w = word_at(b[23:2]);
		by = w[8*b[1:0] +: 8];
		return (k % 2 == 0) ? by[7:4] : by[3:0];
	endfunction

	task automatic store_nibble(input qpimem_pkg::byte_addr_t ba, input int unsigned k,
		input logic [3:0] nib);
		qpimem_pkg::byte_addr_t b;
		logic [31:0] w;
		b = ba + 24'(k / 2);
		w = word_at(b[23:2]);
		if (k % 2 == 0)
			w[8*b[1:0] + 4 +: 4] = nib;
		else
			w[8*b[1:0] +: 4] = nib;
		mem[b[23:2]] = w;
	endtask

	// Command, address, then write data on rising sclk
	// sclk is low whenever cs_n falls, so that case clears the count
	always @(posedge sclk or negedge cs_n) begin
		if (!sclk) begin
			sclk_cnt = 0;
		end else if (cs_n === 1'b0) begin
			if (sclk_cnt < 2)
				cmd = {cmd[3:0], pins.sio_out};
			else if (sclk_cnt < 8)
				base = {base[19:0], pins.sio_out};
			else if (cmd == qpimem_pkg::QPI_CMD_WRITE)
				store_nibble(base, sclk_cnt - 8, pins.sio_out);
			sclk_cnt = sclk_cnt + 1;
		end
	end

	// Read data goes out on falling sclk once the wait clocks have passed
	always @(negedge sclk) begin
		if ((cs_n === 1'b0) && (cmd == qpimem_pkg::QPI_CMD_READ) &&
			(sclk_cnt >= 8 + qpimem_pkg::QPI_READ_WAIT))
			drive = nibble_at(base, sclk_cnt - 8 - qpimem_pkg::QPI_READ_WAIT);
	end

endmodule

// ==== sim/qpimem_checker.sv ====
`timescale 1ns/1ps

module qpimem_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  qpimem_pkg::cpu_req_t   host_req,
	input  qpimem_pkg::cpu_rsp_t   host_rsp,
	input  qpimem_pkg::qpi_pins_t  pins,
	output int                     err_cnt,
	output int                     ready_cnt,
	output int                     rd_lines,
	output int                     wr_lines,
	output qpimem_pkg::byte_addr_t last_wr_base
);

	// sclk rising edges per full-line transfer
	localparam int READ_CLOCKS = 8 + qpimem_pkg::QPI_READ_WAIT + 8 * qpimem_pkg::CACHELINE_WORDS;
	localparam int WRITE_CLOCKS = 8 + 8 * qpimem_pkg::CACHELINE_WORDS;

	// Host writes merged by byte enable
	logic [31:0] shadow [logic [qpimem_pkg::ADDR_WIDTH-1:0]];

	int errors = 0;
	int readies = 0;
	int reads = 0;
	int writes = 0;
	qpimem_pkg::byte_addr_t wr_base = '0;
	logic sclk;
	logic cs_n;
	int unsigned sclk_cnt = 0;
	logic [7:0] cmd = 8'h00;
	qpimem_pkg::byte_addr_t base = '0;
	logic [31:0] exp;
	logic [31:0] merged;
	logic [3:0] exp_oe;

	assign sclk = pins.sclk;
	assign cs_n = pins.cs_n;
	assign err_cnt = errors;
	assign ready_cnt = readies;
	assign rd_lines = reads;
	assign wr_lines = writes;
	assign last_wr_base = wr_base;

	// Expected memory word from the fill pattern or the shadow
	function automatic logic [31:0] ref_word(input logic [qpimem_pkg::ADDR_WIDTH-1:0] a);
		if (shadow.exists(a))
			return shadow[a];
		return 32'(a) * 32'h9E37_79B9;
	endfunction

	// Request is still held in the cycle ready is seen
	always @(posedge clk) begin
		if (!rst && host_rsp.ready) begin
			readies = readies + 1;
			if (host_req.ren) begin
				exp = ref_word(host_req.addr);
				if (host_rsp.rdata !== exp) begin
					errors = errors + 1;
					$display("error at %0t ns: host_rsp.rdata = %h, expected %h (addr %h)",
						$time, host_rsp.rdata, exp, host_req.addr);
				end
			end else if (host_req.wen != 4'b0000) begin
				merged = ref_word(host_req.addr);
				for (int b = 0; b < 4; b++) begin
					if (host_req.wen[b])
						merged[8*b +: 8] = host_req.wdata[8*b +: 8];
				end
				shadow[host_req.addr] = merged;
			end else begin
				errors = errors + 1;
				$display("ready came at %0t ns while no request was held", $time);
			end
		end
	end

	// Pin decode of command and line address
	always @(posedge sclk or negedge cs_n) begin
		if (!sclk) begin
			sclk_cnt = 0;
		end else if (cs_n === 1'b0) begin
			// Controller drives command, address and write data
			if ((sclk_cnt < 8) || (cmd == qpimem_pkg::QPI_CMD_WRITE))
				exp_oe = 4'hf;
			else
				exp_oe = 4'h0;
			if (pins.sio_oe !== exp_oe) begin
				errors = errors + 1;
				$display("error at %0t ns: pins.sio_oe = %h, expected %h",
					$time, pins.sio_oe, exp_oe);
			end
			if (sclk_cnt < 2)
				cmd = {cmd[3:0], pins.sio_out};
			else if (sclk_cnt < 8)
				base = {base[19:0], pins.sio_out};
			sclk_cnt = sclk_cnt + 1;
		end
	end

	// Classify each transfer as cs_n goes back high
	always @(posedge cs_n) begin
		if (!rst && (sclk_cnt >= 2)) begin
			if (cmd == qpimem_pkg::QPI_CMD_READ) begin
				reads = reads + 1;
				if (sclk_cnt != READ_CLOCKS) begin
					errors = errors + 1;
					$display("error at %0t ns: read transfer sclk count = %0d, expected %0d",
						$time, sclk_cnt, READ_CLOCKS);
				end
			end else if (cmd == qpimem_pkg::QPI_CMD_WRITE) begin
				writes = writes + 1;
				wr_base = base;
				if (sclk_cnt != WRITE_CLOCKS) begin
					errors = errors + 1;
					$display("error at %0t ns: write transfer sclk count = %0d, expected %0d",
						$time, sclk_cnt, WRITE_CLOCKS);
				end
			end else begin
				errors = errors + 1;
				$display("unknown QPI command %h in transfer ending at %0t ns", cmd, $time);
			end
		end
	end

endmodule

// ==== sim/tb_qpimem_cached.sv ====
`timescale 1ns/1ps

module tb_qpimem_cached;

	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 8;
	localparam logic [31:0] SEED = 32'h806a_d7d4;
	localparam int TEST_CT = 5;
	localparam int RANDOM_OPS = 500;
	// Worst dirty miss is a line writeback, a line refill and the hit
	localparam int MAX_OPS = 600;
	localparam int MISS_CYCLES = 200;
	localparam int TIMEOUT_CYCLES = MAX_OPS * MISS_CYCLES;

	logic clk = 1'b0;
	logic rst;
	qpimem_pkg::cpu_req_t host_req;
	qpimem_pkg::cpu_rsp_t host_rsp;
	qpimem_pkg::qpi_pins_t pins;
	logic [3:0] sio_in;

	int err_cnt;
	int ready_cnt;
	int rd_lines;
	int wr_lines;
	qpimem_pkg::byte_addr_t last_wr_base;

	int cycle_cnt = 0;
	int passed = 0;
	int failed = 0;
	// Counter values at the start of the current test
	int e0;
	int q0;
	int r0;
	int w0;

	qpimem_cached_top dut_i (
		.clk      (clk),
		.rst      (rst),
		.host_req (host_req),
		.sio_in   (sio_in),
		.host_rsp (host_rsp),
		.pins     (pins)
	);

	psram_model mem_i (
		.pins   (pins),
		.sio_in (sio_in)
	);

	qpimem_checker chk_i (
		.clk          (clk),
		.rst          (rst),
		.host_req     (host_req),
		.host_rsp     (host_rsp),
		.pins         (pins),
		.err_cnt      (err_cnt),
		.ready_cnt    (ready_cnt),
		.rd_lines     (rd_lines),
		.wr_lines     (wr_lines),
		.last_wr_base (last_wr_base)
	);

	always #CLK_HALF clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout, run still going after %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic qpimem_pkg::word_addr_t make_addr(input int tag, input int set,
		input int off);
		qpimem_pkg::word_addr_t a;
		a.tag = qpimem_pkg::cache_tag_t'(tag);
		a.set = qpimem_pkg::cache_set_t'(set);
		a.offset = qpimem_pkg::cache_offset_t'(off);
		return a;
	endfunction

	// Byte address of a line as it shows on the pins
	function automatic qpimem_pkg::byte_addr_t line_base(input int tag, input int set);
		qpimem_pkg::word_addr_t a;
		a = make_addr(tag, set, 0);
		return {a, 2'b00};
	endfunction

	// Fields settle a cycle before the strobe, strobe held until ready
	task automatic access(input qpimem_pkg::word_addr_t a, input logic [3:0] wen,
		input logic [31:0] wdata);
		host_req.addr = a;
		host_req.wdata = wdata;
		@(posedge clk);
		#1;
		host_req.ren = (wen == 4'b0000);
		host_req.wen = wen;
		do @(posedge clk); while (!host_rsp.ready);
		#1;
		host_req.ren = 1'b0;
		host_req.wen = 4'b0000;
	endtask

	task automatic read_word(input int tag, input int set, input int off);
		access(make_addr(tag, set, off), 4'b0000, 32'h0);
	endtask

	task automatic write_word(input int tag, input int set, input int off,
		input logic [3:0] wen, input logic [31:0] wdata);
		access(make_addr(tag, set, off), wen, wdata);
	endtask

	task automatic start_test();
		e0 = err_cnt;
		q0 = ready_cnt;
		r0 = rd_lines;
		w0 = wr_lines;
	endtask

	task automatic finish_test(input int num, input string name, input bit ok);
		$display("test %0d %s: %s (read lines %0d, write lines %0d, errors %0d)", num, name,
			ok ? "pass" : "fail", rd_lines - r0, wr_lines - w0, err_cnt - e0);
		if (ok)
			passed++;
		else
			failed++;
	endtask

	initial begin
		bit ok;
		int r1;
		int ra;
		logic [3:0] wen;
		host_req = '0;
		rst = 1'b1;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// Cold reads over two lines
		start_test();
		for (int s = 1; s <= 2; s++) begin
			for (int o = 0; o < 4; o++)
				read_word(16'h0012, s, o);
		end
		ok = (rd_lines - r0 == 2) && (wr_lines == w0) && (err_cnt == e0);
		finish_test(1, "cold reads", ok);

		// Partial writes into one line, then read back
		start_test();
		write_word(16'h0034, 3, 0, 4'b0001, 32'h1111_11a5);
		write_word(16'h0034, 3, 1, 4'b0110, 32'h2222_2222);
		write_word(16'h0034, 3, 2, 4'b1000, 32'h3c33_3333);
		write_word(16'h0034, 3, 3, 4'b1111, 32'h4444_4444);
		write_word(16'h0034, 3, 0, 4'b1100, 32'h5555_0000);
		for (int o = 0; o < 4; o++)
			read_word(16'h0034, 3, o);
		ok = (rd_lines - r0 == 1) && (wr_lines == w0) && (err_cnt == e0);
		finish_test(2, "byte writes", ok);

		// Three dirty tags in set 5, C evicts A
		start_test();
		write_word(16'h0101, 5, 0, 4'b1111, 32'hA0A0_0001);
		write_word(16'h0101, 5, 2, 4'b0011, 32'h1234_5678);
		write_word(16'h0202, 5, 1, 4'b1111, 32'hB0B0_0002);
		write_word(16'h0303, 5, 0, 4'b1100, 32'hC0C0_0003);
		ok = (wr_lines - w0 == 1) && (last_wr_base == line_base(16'h0101, 5));
		// Bringing A back pushes B out, not A again
		read_word(16'h0101, 5, 0);
		read_word(16'h0101, 5, 2);
		read_word(16'h0101, 5, 1);
		ok = ok && (wr_lines - w0 == 2) && (last_wr_base == line_base(16'h0202, 5));
		ok = ok && (err_cnt == e0);
		finish_test(3, "writeback", ok);

		// LRU order in set 7, touching A makes B the victim of C
		start_test();
		read_word(16'h0111, 7, 0);
		read_word(16'h0222, 7, 0);
		read_word(16'h0111, 7, 1);
		read_word(16'h0333, 7, 0);
		r1 = rd_lines;
		read_word(16'h0111, 7, 3);
		ra = rd_lines - r1;
		read_word(16'h0222, 7, 2);
		ok = (ra == 0) && (rd_lines - r1 == 1) && (wr_lines == w0) && (err_cnt == e0);
		finish_test(4, "lru", ok);

		// Random mix over sets 8 to 15 and six tags
		start_test();
		for (int i = 0; i < RANDOM_OPS; i++) begin
			if ($urandom % 2 == 0)
				wen = 4'b0000;
			else
				wen = 4'($urandom % 15 + 1);
			write_word(16'h0500 + int'($urandom % 6), 8 + int'($urandom % 8),
				int'($urandom % 4), wen, $urandom);
		end
		ok = (ready_cnt - q0 == RANDOM_OPS) && (err_cnt == e0);
		finish_test(5, "random mix", ok);

		$display("tests %0d, passed %0d, failed %0d, checker errors %0d, cycles %0d",
			TEST_CT, passed, failed, err_cnt, cycle_cnt);
		if ((failed == 0) && (err_cnt == 0))
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== src/qpimem_cache.sv ====
`timescale 1ns/1ps

module qpimem_cache (
	input  logic                  clk,
	input  logic                  rst,
	input  qpimem_pkg::cpu_req_t  req,
	input  qpimem_pkg::qpi_rsp_t  qpi_rsp,
	output qpimem_pkg::cpu_rsp_t  rsp,
	output qpimem_pkg::qpi_req_t  qpi_req
);

	// Line data, indexed by {way, set, offset}
	logic [31:0] data_mem [qpimem_pkg::CACHELINE_CT * qpimem_pkg::CACHELINE_WORDS];

	logic active;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	qpimem_pkg::cache_tag_t victim_tag;
	logic hit_go;
	logic touch;
	logic mark_dirty;
	logic clean;
	logic fill;

	logic ready_q;
	logic [31:0] rdata_q;

	// Line transfer state
	logic do_read_q;
	logic do_write_q;
	logic busy;
	qpimem_pkg::byte_addr_t addr_q;
	logic [31:0] wdata_q;
	qpimem_pkg::cache_offset_t word_cnt;
	qpimem_pkg::cache_offset_t next_cnt;
	logic last_word;

	qpimem_cache_tags tags_i (
		.clk          (clk),
		.rst          (rst),
		.addr         (req.addr),
		.touch        (touch),
		.mark_dirty   (mark_dirty),
		.clean        (clean),
		.fill         (fill),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag)
	);

	assign active = req.ren || (req.wen != 4'b0000);
	// Request still held in the ready cycle, so skip it there
	assign hit_go = active && hit && !ready_q;
	assign touch = hit_go;
	assign mark_dirty = hit_go && (req.wen != 4'b0000);

	assign busy = do_read_q || do_write_q;
	assign next_cnt = word_cnt + 1'b1;
	assign last_word = busy && qpi_rsp.next_word && (word_cnt == '1);
	assign clean = do_write_q && last_word;
	assign fill = do_read_q && last_word;

	// Hit path and refill writes into the data array
	always_ff @(posedge clk) begin
		if (hit_go) begin
			rdata_q <= data_mem[{hit_way, req.addr.set, req.addr.offset}];
			for (int b = 0; b < 4; b++) begin
				if (req.wen[b])
					data_mem[{hit_way, req.addr.set, req.addr.offset}][8*b +: 8] <= req.wdata[8*b +: 8];
			end
		end
		if (do_read_q && qpi_rsp.next_word)
			data_mem[{victim_way, req.addr.set, word_cnt}] <= qpi_rsp.rdata;
	end

	always_ff @(posedge clk) begin
		if (rst)
			ready_q <= 1'b0;
		else
			ready_q <= hit_go;
	end

	// Miss sequencer, writeback first if the victim is dirty
	always_ff @(posedge clk) begin
		if (rst) begin
			do_read_q <= 1'b0;
			do_write_q <= 1'b0;
			word_cnt <= '0;
		end else if (!busy) begin
			if (active && !hit && qpi_rsp.idle) begin
				word_cnt <= '0;
				if (victim_dirty)
					do_write_q <= 1'b1;
				else
					do_read_q <= 1'b1;
			end
		end else if (qpi_rsp.next_word) begin
			word_cnt <= next_cnt;
			// Drop the strobe one cycle after the fourth word
			if (word_cnt == '1) begin
				do_read_q <= 1'b0;
				do_write_q <= 1'b0;
			end
		end
	end

	// Line base address and outgoing word, stable while a transfer runs
	always_ff @(posedge clk) begin
		if (!busy) begin
			if (victim_dirty)
				addr_q <= {victim_tag, req.addr.set, {(qpimem_pkg::OFFSET_BITS + 2){1'b0}}};
			else
				addr_q <= {req.addr.tag, req.addr.set, {(qpimem_pkg::OFFSET_BITS + 2){1'b0}}};
			wdata_q <= data_mem[{victim_way, req.addr.set, {qpimem_pkg::OFFSET_BITS{1'b0}}}];
		end else if (do_write_q && qpi_rsp.next_word) begin
			wdata_q <= data_mem[{victim_way, req.addr.set, next_cnt}];
		end
	end

	assign rsp.rdata = rdata_q;
	assign rsp.ready = ready_q;
	assign qpi_req.do_read = do_read_q;
	assign qpi_req.do_write = do_write_q;
	assign qpi_req.addr = addr_q;
	assign qpi_req.wdata = wdata_q;

	assert property (@(posedge clk) disable iff (rst) !(qpi_req.do_read && qpi_req.do_write));
	// One ready per request
	assert property (@(posedge clk) disable iff (rst) rsp.ready |=> !rsp.ready);

endmodule

// ==== src/qpimem_cache_tags.sv ====
`timescale 1ns/1ps

module qpimem_cache_tags (
	input  logic                    clk,
	input  logic                    rst,
	input  qpimem_pkg::word_addr_t  addr,
	input  logic                    touch,
	input  logic                    mark_dirty,
	input  logic                    clean,
	input  logic                    fill,
	output logic                    hit,
	output logic                    hit_way,
	output logic                    victim_way,
	output logic                    victim_dirty,
	output qpimem_pkg::cache_tag_t  victim_tag
);

	// Tag store, one entry per way and set
	qpimem_pkg::cache_tag_t tag_mem [qpimem_pkg::CACHE_WAYS][qpimem_pkg::CACHE_SETS];

	// Per-line flags
	logic [qpimem_pkg::CACHE_WAYS-1:0][qpimem_pkg::CACHE_SETS-1:0] valid;
	logic [qpimem_pkg::CACHE_WAYS-1:0][qpimem_pkg::CACHE_SETS-1:0] dirty;

	// One LRU bit per set, it names the way to evict next
	logic [qpimem_pkg::CACHE_SETS-1:0] lru;

	logic [qpimem_pkg::CACHE_WAYS-1:0] way_hit;

	// Tag compare in both ways of the addressed set
	always_comb begin
		for (int w = 0; w < qpimem_pkg::CACHE_WAYS; w++) begin
			way_hit[w] = valid[w][addr.set] && (tag_mem[w][addr.set] == addr.tag);
		end
	end

	assign hit = |way_hit;
	// Two ways only, way 1 wins the encode
	assign hit_way = way_hit[1];

	assign victim_way = lru[addr.set];
	assign victim_dirty = dirty[victim_way][addr.set];
	assign victim_tag = tag_mem[victim_way][addr.set];

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else begin
			// Point LRU at the way not just used
			if (touch)
				lru[addr.set] <= ~hit_way;
			if (mark_dirty)
				dirty[hit_way][addr.set] <= 1'b1;
			// Writeback finished
			if (clean)
				dirty[victim_way][addr.set] <= 1'b0;
			if (fill)
				valid[victim_way][addr.set] <= 1'b1;
		end
	end

	// New tag lands in the victim way at the end of a refill
	always_ff @(posedge clk) begin
		if (fill)
			tag_mem[victim_way][addr.set] <= addr.tag;
	end

	// Same tag never resident twice in one set
	assert property (@(posedge clk) disable iff (rst) !(&way_hit));

endmodule

// ==== src/qpimem_cached_top.sv ====
`timescale 1ns/1ps

module qpimem_cached_top (
	input  logic                   clk,
	input  logic                   rst,
	input  qpimem_pkg::cpu_req_t   host_req,
	input  logic [3:0]             sio_in,
	output qpimem_pkg::cpu_rsp_t   host_rsp,
	output qpimem_pkg::qpi_pins_t  pins
);

	// Word stream between cache and serial engine
	qpimem_pkg::qpi_req_t qpi_req;
	qpimem_pkg::qpi_rsp_t qpi_rsp;

	qpimem_cache cache_i (
		.clk     (clk),
		.rst     (rst),
		.req     (host_req),
		.qpi_rsp (qpi_rsp),
		.rsp     (host_rsp),
		.qpi_req (qpi_req)
	);

	// Pin side of the PSRAM
	qpimem_iface iface_i (
		.clk    (clk),
		.rst    (rst),
		.req    (qpi_req),
		.sio_in (sio_in),
		.rsp    (qpi_rsp),
		.pins   (pins)
	);

endmodule

// ==== src/qpimem_iface.sv ====
`timescale 1ns/1ps

module qpimem_iface (
	input  logic                   clk,
	input  logic                   rst,
	input  qpimem_pkg::qpi_req_t   req,
	input  logic [3:0]             sio_in,
	output qpimem_pkg::qpi_rsp_t   rsp,
	output qpimem_pkg::qpi_pins_t  pins
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CMD,
		ST_ADDR,
		ST_WAIT,
		ST_DATA,
		ST_DESEL
	} state_t;

	state_t state;
	logic sclk_q;
	logic cs_n_q;
	logic [3:0] oe_q;
	logic next_word_q;
	logic rd_mode;
	logic [2:0] nib_cnt;
	// Outgoing nibble is always the top of this register
	logic [31:0] sr;
	logic [31:0] rdata_q;

	logic start;
	logic fall;
	logic load_word;
	logic shift_out;
	logic sample;
	logic word_in;

	// Byte 0 travels first on the bus
	function automatic logic [31:0] swap32(input logic [31:0] w);
		swap32 = {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign start = (state == ST_IDLE) && (req.do_read || req.do_write);
	// sclk high now, so this edge is a falling one
	assign fall = sclk_q;

	// Write words are taken after the last address nibble and at each word end
	assign load_word = !rd_mode && fall &&
		(((state == ST_ADDR) && (nib_cnt == 3'd5)) ||
		 ((state == ST_DATA) && (nib_cnt == 3'd7) && req.do_write));
	assign shift_out = fall && !load_word &&
		((state == ST_CMD) || (state == ST_ADDR) || ((state == ST_DATA) && !rd_mode));
	// Read nibbles are sampled on the rising edge
	assign sample = (state == ST_DATA) && rd_mode && !sclk_q && req.do_read;
	assign word_in = sample && (nib_cnt == 3'd7);

	always_ff @(posedge clk) begin
		if (start)
			sr <= {req.do_read ? qpimem_pkg::QPI_CMD_READ : qpimem_pkg::QPI_CMD_WRITE, req.addr};
		else if (load_word)
			sr <= swap32(req.wdata);
		else if (shift_out)
			sr <= {sr[27:0], 4'h0};
		else if (sample)
			sr <= {sr[27:0], sio_in};
		if (word_in)
			rdata_q <= swap32({sr[27:0], sio_in});
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			sclk_q <= 1'b0;
			cs_n_q <= 1'b1;
			oe_q <= 4'h0;
			next_word_q <= 1'b0;
			rd_mode <= 1'b0;
			nib_cnt <= '0;
		end else begin
			next_word_q <= load_word || word_in;
			case (state)
				ST_IDLE: begin
					sclk_q <= 1'b0;
					if (start) begin
						state <= ST_CMD;
						cs_n_q <= 1'b0;
						oe_q <= 4'hf;
						rd_mode <= req.do_read;
						nib_cnt <= '0;
					end
				end
				// Two command nibbles
				ST_CMD: begin
					sclk_q <= ~sclk_q;
					if (fall) begin
						if (nib_cnt == 3'd1) begin
							state <= ST_ADDR;
							nib_cnt <= '0;
						end else begin
							nib_cnt <= nib_cnt + 3'd1;
						end
					end
				end
				// Six address nibbles, high first
				ST_ADDR: begin
					sclk_q <= ~sclk_q;
					if (fall) begin
						if (nib_cnt == 3'd5) begin
							nib_cnt <= '0;
							if (rd_mode) begin
								// Release the bus for the turnaround
								state <= ST_WAIT;
								oe_q <= 4'h0;
							end else begin
								state <= ST_DATA;
							end
						end else begin
							nib_cnt <= nib_cnt + 3'd1;
						end
					end
				end
				// Memory drives the first data nibble on the last falling edge here
				ST_WAIT: begin
					sclk_q <= ~sclk_q;
					if (fall) begin
						if (nib_cnt == 3'(qpimem_pkg::QPI_READ_WAIT - 1)) begin
							state <= ST_DATA;
							nib_cnt <= '0;
						end else begin
							nib_cnt <= nib_cnt + 3'd1;
						end
					end
				end
				ST_DATA: begin
					if (rd_mode && !sclk_q && !req.do_read) begin
						// Line done, stop before the next rising edge
						state <= ST_DESEL;
						sclk_q <= 1'b0;
						cs_n_q <= 1'b1;
						nib_cnt <= '0;
					end else begin
						sclk_q <= ~sclk_q;
						if (sample)
							nib_cnt <= nib_cnt + 3'd1;
						if (!rd_mode && fall) begin
							nib_cnt <= nib_cnt + 3'd1;
							// Word boundary with no more data to send
							if ((nib_cnt == 3'd7) && !req.do_write) begin
								state <= ST_DESEL;
								cs_n_q <= 1'b1;
								oe_q <= 4'h0;
								nib_cnt <= '0;
							end
						end
					end
				end
				// cs_n high for two cycles before the next command
				ST_DESEL: begin
					sclk_q <= 1'b0;
					oe_q <= 4'h0;
					if (nib_cnt == 3'd0)
						nib_cnt <= 3'd1;
					else
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign rsp.next_word = next_word_q;
	assign rsp.rdata = rdata_q;
	assign rsp.idle = (state == ST_IDLE);

	assign pins.sclk = sclk_q;
	assign pins.cs_n = cs_n_q;
	assign pins.sio_oe = oe_q;
	assign pins.sio_out = sr[31:28];

	// No contention while the memory drives read data
	assert property (@(posedge clk) disable iff (rst)
		((state == ST_DATA) && rd_mode) |-> (pins.sio_oe == 4'h0));

endmodule

// ==== src/qpimem_pkg.sv ====
package qpimem_pkg;

	// Word-addressed cache geometry
	localparam int ADDR_WIDTH = 22;
	localparam int CACHELINE_WORDS = 4;
	localparam int CACHELINE_CT = 32;
	localparam int CACHE_WAYS = 2;
	localparam int CACHE_SETS = CACHELINE_CT / CACHE_WAYS;
	localparam int OFFSET_BITS = $clog2(CACHELINE_WORDS);
	localparam int SET_BITS = $clog2(CACHE_SETS);
	localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFFSET_BITS;

	// QPI command bytes and read turnaround in sclk periods
	localparam logic [7:0] QPI_CMD_READ = 8'hEB;
	localparam logic [7:0] QPI_CMD_WRITE = 8'h38;
	localparam int QPI_READ_WAIT = 6;

	typedef logic [TAG_BITS-1:0] cache_tag_t;
	typedef logic [SET_BITS-1:0] cache_set_t;
	typedef logic [OFFSET_BITS-1:0] cache_offset_t;

	// Host word address with the tag in the high bits
	typedef struct packed {
		cache_tag_t tag;
		cache_set_t set;
		cache_offset_t offset;
	} word_addr_t;

	// Byte address on the QPI bus
	typedef logic [ADDR_WIDTH+1:0] byte_addr_t;

	// Host request held until ready
	typedef struct packed {
		word_addr_t addr;
		logic [3:0] wen;
		logic ren;
		logic [31:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic ready;
	} cpu_rsp_t;

	// Line transfer request from the cache to the serial engine
	typedef struct packed {
		logic do_read;
		logic do_write;
		byte_addr_t addr;
		logic [31:0] wdata;
	} qpi_req_t;

	typedef struct packed {
		logic next_word;
		logic [31:0] rdata;
		logic idle;
	} qpi_rsp_t;

	// Outgoing pins of the QPI bus
	typedef struct packed {
		logic sclk;
		logic cs_n;
		logic [3:0] sio_oe;
		logic [3:0] sio_out;
	} qpi_pins_t;

endpackage
